/* verilog.f */
+incdir+verilog
verilog/frv_isa_pkg.sv
verilog/frv_dispatch_pkg.sv
verilog/frv_stage_ifs.sv
verilog/frv_gprs.sv
verilog/frv_pipeline_register.sv
verilog/frv_pipeline_dispatch.sv
verilog/frv_dispatch_top.sv
bench/tb_clock_gen.sv
bench/frv_dispatch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frv_dispatch_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/frv_dispatch_tb.sv */
// --------------------------------------------------
// Dispatch stage testbench
// Reference model runs on the falling edge from the
// decode inputs, a GPR shadow and the fwd buses
// Concurrent assertions compare s3 on rising edges
// Run is bounded by a cycle counter
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "frv_consts.svh"

module frv_dispatch_tb import frv_isa_pkg::*, frv_dispatch_pkg::*; ();

    localparam int TEST_CYCLES = 200 + 100 + 100 + 150 + 100; // Budget per test
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic g_clk, arst_n, s2_p_busy, s2_p_valid, s2_trap, flush;
    reg_addr_t s2_rd, s2_rs1, s2_rs2, fwd_s3_rd, fwd_s4_rd, gpr_rd, s3_rd;
    xword_t s2_imm, s2_pc, fwd_s3_wdata, fwd_s4_wdata, gpr_wdata;
    xword_t s3_opr_a, s3_opr_b, s3_opr_c, s3_pc;
    uop_t s2_uop, s3_uop;
    fu_t s2_fu, s3_fu;
    opr_src_t s2_opr_src;
    instr_size_t s2_size, s3_size;
    instr_t s2_instr, s3_instr;
    logic fwd_s3_load, fwd_s3_csr, fwd_s4_csr, gpr_wen, s3_trap, s3_p_busy, s3_p_valid;

    xword_t shadow [0:31];         // GPR contents as the model sees them
    logic [31:0] lfsr_state;
    int err_count, test_count, cycles;

    // nxt_* built at negedge and exp_* mirrors the s3 register
    logic m_bubble, m_reg_busy, exp_busy, exp_valid;
    reg_addr_t nxt_rd, exp_rd;
    xword_t nxt_a, nxt_b, nxt_c, exp_a, exp_b, exp_c, exp_pc;
    uop_t exp_uop;
    fu_t exp_fu;
    instr_size_t exp_size;
    instr_t exp_instr;
    logic exp_trap;

    tb_clock_gen clk0 (.clk(g_clk));

    frv_dispatch_top dut0 (.*);

    // --------------------------------------------------
    // Random source
    // --------------------------------------------------
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000)
                                       : (lfsr_state >> 1); // Galois step
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic xword_t fwd_value(reg_addr_t src);
        if (src != 5'd0 && src == fwd_s3_rd) return fwd_s3_wdata; // Newest wins
        if (src != 5'd0 && src == fwd_s4_rd) return fwd_s4_wdata;
        if (src == 5'd0) return '0;
        return shadow[src];
    endfunction

    // True when the decoded instruction reads register r
    function automatic logic reads_reg(reg_addr_t r);
        return (s2_rs1 == r) || (s2_rs2 == r);
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    always @(negedge g_clk) begin
        xword_t r1, r2, pcim;
        r1 = fwd_value(s2_rs1);
        r2 = fwd_value(s2_rs2);
        pcim = s2_pc + s2_imm;
        m_bubble = s2_p_valid &&
            (((fwd_s3_load || fwd_s3_csr) && reads_reg(fwd_s3_rd)) ||
             (fwd_s4_csr && reads_reg(fwd_s4_rd)));
        m_reg_busy = exp_valid && s3_p_busy;
        exp_busy = m_bubble || m_reg_busy;
        nxt_a = (s2_opr_src[`FRV_DIS_OPRA_RS1] ? r1 : '0) |
                (s2_opr_src[`FRV_DIS_OPRA_PCIM] ? pcim : '0) |
                (s2_opr_src[`FRV_DIS_OPRA_CSRI] ? xword_t'(s2_rs1) : '0);
        nxt_b = (s2_opr_src[`FRV_DIS_OPRB_RS2] ? r2 : '0) |
                (s2_opr_src[`FRV_DIS_OPRB_IMM] ? s2_imm : '0);
        nxt_c = (s2_opr_src[`FRV_DIS_OPRC_RS2] ? r2 : '0) |
                (s2_opr_src[`FRV_DIS_OPRC_CSRA] ? xword_t'(s2_imm[31:20]) : '0) |
                (s2_opr_src[`FRV_DIS_OPRC_PCIM] ? pcim : '0);
        nxt_rd = s2_rd;
        if (s2_fu[`FRV_P_FU_LSU] && s2_uop[`FRV_LSU_STORE]) nxt_rd = 5'd0; // Store
        if (s2_fu[`FRV_P_FU_CFU] && s2_uop[4:3] == 2'b00) nxt_rd = 5'd0;   // Branch
    end

    always @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_valid <= 1'b0;
            for (int i = 0; i < 32; i++) shadow[i] <= '0;
        end else begin
            if (gpr_wen && gpr_rd != 5'd0) shadow[gpr_rd] <= gpr_wdata;
            if (flush || (m_bubble && !m_reg_busy)) begin
                exp_valid <= 1'b0;                            // Bubble or flush
            end else if (!m_reg_busy) begin
                exp_valid <= s2_p_valid;
                if (s2_p_valid) begin
                    {exp_rd, exp_a, exp_b, exp_c} <= {nxt_rd, nxt_a, nxt_b, nxt_c};
                    {exp_pc, exp_uop, exp_fu} <= {s2_pc, s2_uop, s2_fu};
                    {exp_size, exp_instr, exp_trap} <= {s2_size, s2_instr, s2_trap};
                end
            end
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_valid: assert property (@(posedge g_clk) disable iff (!arst_n) s3_p_valid == exp_valid)
        else begin
            err_count++;
            $display("Error: s3_p_valid got 0x%h expected 0x%h",
                     $sampled(s3_p_valid), $sampled(exp_valid));
        end
    a_busy: assert property (@(posedge g_clk) disable iff (!arst_n) s2_p_busy == exp_busy)
        else begin
            err_count++;
            $display("Error: s2_p_busy got 0x%h expected 0x%h",
                     $sampled(s2_p_busy), $sampled(exp_busy));
        end
    a_rd: assert property (@(posedge g_clk) disable iff (!arst_n) s3_p_valid |-> s3_rd == exp_rd)
        else begin
            err_count++;
            $display("Error: s3_rd got 0x%h expected 0x%h",
                     $sampled(s3_rd), $sampled(exp_rd));
        end
    a_opr_a: assert property (@(posedge g_clk) disable iff (!arst_n)
        s3_p_valid |-> s3_opr_a == exp_a)
        else begin
            err_count++;
            $display("Error: s3_opr_a got 0x%h expected 0x%h",
                     $sampled(s3_opr_a), $sampled(exp_a));
        end
    a_opr_b: assert property (@(posedge g_clk) disable iff (!arst_n)
        s3_p_valid |-> s3_opr_b == exp_b)
        else begin
            err_count++;
            $display("Error: s3_opr_b got 0x%h expected 0x%h",
                     $sampled(s3_opr_b), $sampled(exp_b));
        end
    a_opr_c: assert property (@(posedge g_clk) disable iff (!arst_n)
        s3_p_valid |-> s3_opr_c == exp_c)
        else begin
            err_count++;
            $display("Error: s3_opr_c got 0x%h expected 0x%h",
                     $sampled(s3_opr_c), $sampled(exp_c));
        end
    a_fields: assert property (@(posedge g_clk) disable iff (!arst_n)
        s3_p_valid |-> {s3_pc, s3_uop, s3_fu, s3_size, s3_instr, s3_trap} ==
                       {exp_pc, exp_uop, exp_fu, exp_size, exp_instr, exp_trap})
        else begin
            err_count++;
            $display("Error: s3_pc/uop/fu/size/instr/trap got 0x%h expected 0x%h",
                     $sampled({s3_pc, s3_uop, s3_fu, s3_size, s3_instr, s3_trap}),
                     $sampled({exp_pc, exp_uop, exp_fu, exp_size, exp_instr, exp_trap}));
        end

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------
    task automatic present(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2, xword_t imm,
                           uop_t uop, fu_t fu, opr_src_t src);
        s2_p_valid <= 1'b1;
        {s2_rd, s2_rs1, s2_rs2, s2_imm, s2_uop, s2_fu, s2_opr_src} <=
            {rd, rs1, rs2, imm, uop, fu, src};
        s2_pc <= rand_bits(32);
        s2_instr <= rand_bits(32);
        s2_size <= instr_size_t'(rand_bits(2));
        s2_trap <= 1'(rand_bits(1));
    endtask

    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge g_clk);
            taken = !s2_p_busy;                   // Stable half a cycle before edge
            @(posedge g_clk);
        end
        s2_p_valid <= 1'b0;
    endtask

    task automatic issue_random(logic [7:0] src_extra);
        logic [1:0] sel;
        opr_src_t src;
        sel = 2'(rand_bits(2));
        src = {5'(rand_bits(5)), 3'b000} | src_extra;
        if (sel != 2'd0) src[sel - 2'd1] = 1'b1; // At most one operand A source
        present(reg_addr_t'(rand_bits(5)), reg_addr_t'(rand_bits(5)),
                reg_addr_t'(rand_bits(5)), rand_bits(32),
                uop_t'(rand_bits(5)), fu_t'(rand_bits(5)), src);
        wait_accept();
    endtask

    task automatic end_test(string name);
        test_count++;
        repeat (3) @(posedge g_clk);
        $display("test %0d %s done, errors so far %0d", test_count, name, err_count);
    endtask

    // Timeout
    always @(posedge g_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        lfsr_state = 32'h19c0;
        {err_count, test_count, cycles} = '0;
        arst_n = 1'b0;
        {s2_p_valid, s2_trap, flush, fwd_s3_load, fwd_s3_csr, fwd_s4_csr} = '0;
        {gpr_wen, s3_p_busy, s2_rd, s2_rs1, s2_rs2, s2_imm, s2_pc} = '0;
        {s2_uop, s2_fu, s2_opr_src, s2_size, s2_instr} = '0;
        {fwd_s3_rd, fwd_s3_wdata, fwd_s4_rd, fwd_s4_wdata, gpr_rd, gpr_wdata} = '0;
        repeat (10) @(posedge g_clk);
        arst_n <= 1'b1;
        @(posedge g_clk);

        // Test 1: random operand assembly
        for (int i = 1; i < 32; i++) begin
            gpr_wen <= 1'b1;
            gpr_rd <= i[4:0];
            gpr_wdata <= rand_bits(32);
            @(posedge g_clk);
        end
        gpr_wen <= 1'b0;
        for (int i = 0; i < 40; i++) issue_random(8'h00);
        end_test("operand assembly");

        // Test 2: forwarding priority and x0
        {fwd_s3_rd, fwd_s4_rd, fwd_s3_wdata, fwd_s4_wdata} <= {5'd5, 5'd5, 32'h1111, 32'h2222};
        present(5'd1, 5'd5, 5'd5, 32'h0, 5'd0, 5'd1, 8'h29);
        wait_accept();
        {fwd_s3_rd, fwd_s4_rd} <= {5'd9, 5'd7};
        present(5'd1, 5'd7, 5'd9, 32'h0, 5'd0, 5'd1, 8'h29);
        wait_accept();
        {fwd_s3_rd, fwd_s4_rd} <= {5'd0, 5'd0};
        present(5'd1, 5'd0, 5'd0, 32'h0, 5'd0, 5'd1, 8'h29);
        wait_accept();
        end_test("forwarding priority");

        // Test 3: load and CSR hazards, cleared after a few cycles
        for (int k = 0; k < 3; k++) begin
            {fwd_s3_rd, fwd_s4_rd} <= {5'd11, 5'd12};
            fwd_s3_load <= (k == 0);
            fwd_s3_csr <= (k == 1);
            fwd_s4_csr <= (k == 2);
            present(5'd3, (k == 1) ? 5'd2 : 5'd11 + 5'(k / 2), (k == 1) ? 5'd11 : 5'd4,
                    rand_bits(32), 5'd0, 5'd1, 8'h29);
            repeat (3) @(posedge g_clk);
            {fwd_s3_load, fwd_s3_csr, fwd_s4_csr} <= 3'b000;
            wait_accept();
        end
        end_test("hazard bubbles");

        // Test 4: back-pressure from execute
        issue_random(8'h00);
        s3_p_busy <= 1'b1;
        present(5'd6, 5'd1, 5'd2, rand_bits(32), 5'd0, 5'd1, 8'h29);
        repeat (5) @(posedge g_clk);
        s3_p_busy <= 1'b0;
        wait_accept();
        for (int i = 0; i < 20; i++) begin
            s3_p_busy <= 1'(rand_bits(1));   // Execute may stall for one cycle
            @(posedge g_clk);
            s3_p_busy <= 1'b0;
            issue_random(8'h00);
        end
        s3_p_busy <= 1'b0;
        end_test("back-pressure");

        // Test 5: flush and destination zeroing
        issue_random(8'h00);
        flush <= 1'b1;
        @(posedge g_clk);
        flush <= 1'b0;
        present(5'd8, 5'd1, 5'd2, 32'h40, 5'h10, 5'h04, 8'h29); // Store
        wait_accept();
        present(5'd9, 5'd1, 5'd2, 32'h80, 5'h02, 5'h08, 8'h82); // Conditional branch
        wait_accept();
        present(5'd10, 5'd1, 5'd2, 32'h80, 5'h08, 5'h08, 8'h82); // Jump keeps rd
        wait_accept();
        end_test("flush and rd zeroing");

        $display("tests run %0d, checks failed %0d", test_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// --------------------------------------------------
// Free running testbench clock, 4 ns period
// Starts low at time zero
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_NS = 2 // Half period in ns
) (
    output logic clk          // Generated clock
);

    initial clk = 1'b0;
    always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire

/* verilog/frv_dispatch_top.sv */
// --------------------------------------------------
// Dispatch stage top level, plain ports only
// Connects to decode (s2), execute (s3) and the
// s3/s4 forwarding and GPR writeback buses
// s4 loads are not checked, data is in the GPRs
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_dispatch_top import frv_isa_pkg::*, frv_dispatch_pkg::*; (
    input  logic        g_clk,        // Core clock
    input  logic        arst_n,       // Async reset, active low
    output logic        s2_p_busy,    // Back-pressure to decode
    input  logic        s2_p_valid,   // Decode output valid
    input  reg_addr_t   s2_rd,
    input  reg_addr_t   s2_rs1,
    input  reg_addr_t   s2_rs2,
    input  xword_t      s2_imm,
    input  xword_t      s2_pc,
    input  uop_t        s2_uop,
    input  fu_t         s2_fu,
    input  logic        s2_trap,
    input  opr_src_t    s2_opr_src,
    input  instr_size_t s2_size,
    input  instr_t      s2_instr,
    input  logic        flush,        // Pipeline flush
    input  reg_addr_t   fwd_s3_rd,    // Execute forwarding
    input  xword_t      fwd_s3_wdata,
    input  logic        fwd_s3_load,
    input  logic        fwd_s3_csr,
    input  reg_addr_t   fwd_s4_rd,    // Writeback forwarding
    input  xword_t      fwd_s4_wdata,
    input  logic        fwd_s4_csr,
    input  logic        gpr_wen,      // Register file write
    input  reg_addr_t   gpr_rd,
    input  xword_t      gpr_wdata,
    output reg_addr_t   s3_rd,        // To execute
    output xword_t      s3_opr_a,
    output xword_t      s3_opr_b,
    output xword_t      s3_opr_c,
    output xword_t      s3_pc,
    output uop_t        s3_uop,
    output fu_t         s3_fu,
    output logic        s3_trap,
    output instr_size_t s3_size,
    output instr_t      s3_instr,
    input  logic        s3_p_busy,    // Execute stalled
    output logic        s3_p_valid    // Record valid for execute
);

    // Names match one to one with the stage ports
    frv_pipeline_dispatch i_dispatch (.*);

endmodule

`default_nettype wire

/* verilog/frv_pipeline_dispatch.sv */
// --------------------------------------------------
// Dispatch stage, s2 to s3
// Bubbles on a source that needs an s3 load/CSR
// result or an s4 CSR result, no x0 exemption
// Forwarding order is s3, then s4, then GPRs
// One cycle latency through the pipeline register
// Trap flag passes straight through
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "frv_consts.svh"

module frv_pipeline_dispatch import frv_isa_pkg::*, frv_dispatch_pkg::*; (
    input  logic        g_clk,        // Core clock
    input  logic        arst_n,       // Async reset, active low
    output logic        s2_p_busy,    // Stage cannot accept
    input  logic        s2_p_valid,   // Decode output valid
    input  reg_addr_t   s2_rd,        // Destination index
    input  reg_addr_t   s2_rs1,       // Source 1 index
    input  reg_addr_t   s2_rs2,       // Source 2 index
    input  xword_t      s2_imm,       // Decoded immediate
    input  xword_t      s2_pc,        // Program counter
    input  uop_t        s2_uop,       // Micro-op
    input  fu_t         s2_fu,        // Functional unit
    input  logic        s2_trap,      // Raise a trap
    input  opr_src_t    s2_opr_src,   // Operand source mask
    input  instr_size_t s2_size,      // Instruction size
    input  instr_t      s2_instr,     // Instruction word
    input  logic        flush,        // Flush this stage
    input  reg_addr_t   fwd_s3_rd,    // Execute destination
    input  xword_t      fwd_s3_wdata, // Execute result
    input  logic        fwd_s3_load,  // Execute holds a load
    input  logic        fwd_s3_csr,   // Execute holds a CSR op
    input  reg_addr_t   fwd_s4_rd,    // Writeback destination
    input  xword_t      fwd_s4_wdata, // Writeback result
    input  logic        fwd_s4_csr,   // Writeback holds a CSR op
    input  logic        gpr_wen,      // GPR write enable
    input  reg_addr_t   gpr_rd,       // GPR write index
    input  xword_t      gpr_wdata,    // GPR write data
    output reg_addr_t   s3_rd,        // Destination index
    output xword_t      s3_opr_a,     // Operand A
    output xword_t      s3_opr_b,     // Operand B
    output xword_t      s3_opr_c,     // Operand C
    output xword_t      s3_pc,        // Program counter
    output uop_t        s3_uop,       // Micro-op
    output fu_t         s3_fu,        // Functional unit
    output logic        s3_trap,      // Raise a trap
    output instr_size_t s3_size,      // Instruction size
    output instr_t      s3_instr,     // Instruction word
    input  logic        s3_p_busy,    // Execute stalled
    output logic        s3_p_valid    // Record valid for execute
);

    frv_gpr_rd_if                             gpr_if ();  // GPR reads
    frv_stage_in_if #(.RLEN(`FRV_PIPE_REG_W)) pipe_if (); // Into s3 reg

    logic                       dis_bubble;    // RAW hazard on a late result
    logic                       no_rd;         // No writeback for this op
    reg_addr_t                  n_s3_rd;       // Destination after zeroing
    xword_t                     dis_rs1;       // rs1 after forwarding
    xword_t                     dis_rs2;       // rs2 after forwarding
    xword_t                     pc_plus_imm;   // Branch/AUIPC target
    xword_t                     csr_imm;       // zimm from rs1 field
    xword_t                     csr_addr;      // CSR number
    xword_t                     n_s3_opr_a;
    xword_t                     n_s3_opr_b;
    xword_t                     n_s3_opr_c;
    logic [`FRV_PIPE_REG_W-1:0] pipe_reg_out;  // Record out of s3 register

    // --------------------------------------------------
    // Hazard bubbling
    // --------------------------------------------------
    assign dis_bubble = s2_p_valid && (
        ((fwd_s3_load || fwd_s3_csr) && (s2_rs1 == fwd_s3_rd || s2_rs2 == fwd_s3_rd)) ||
        (fwd_s4_csr && (s2_rs1 == fwd_s4_rd || s2_rs2 == fwd_s4_rd)));

    assign s2_p_busy = dis_bubble || pipe_if.busy; // Hold decode on either

    // --------------------------------------------------
    // Operand forwarding
    // --------------------------------------------------
    assign gpr_if.rs1_addr = s2_rs1;
    assign gpr_if.rs2_addr = s2_rs2;

    assign dis_rs1 = (|s2_rs1 && s2_rs1 == fwd_s3_rd) ? fwd_s3_wdata :   // Newest first
                     (|s2_rs1 && s2_rs1 == fwd_s4_rd) ? fwd_s4_wdata :
                                                        gpr_if.rs1_data;
    assign dis_rs2 = (|s2_rs2 && s2_rs2 == fwd_s3_rd) ? fwd_s3_wdata :
                     (|s2_rs2 && s2_rs2 == fwd_s4_rd) ? fwd_s4_wdata :
                                                        gpr_if.rs2_data;

    // --------------------------------------------------
    // Operand assembly
    // --------------------------------------------------
    assign pc_plus_imm = s2_pc + s2_imm;
    assign csr_imm     = {{(`FRV_XLEN-5){1'b0}}, s2_rs1};         // Zero extended
    assign csr_addr    = {{(`FRV_XLEN-12){1'b0}}, s2_imm[31:20]};

    // Each operand ORs every source whose mask bit is set
    assign n_s3_opr_a = ({`FRV_XLEN{s2_opr_src[`FRV_DIS_OPRA_RS1]}}  & dis_rs1)     |
                        ({`FRV_XLEN{s2_opr_src[`FRV_DIS_OPRA_PCIM]}} & pc_plus_imm) |
                        ({`FRV_XLEN{s2_opr_src[`FRV_DIS_OPRA_CSRI]}} & csr_imm);
    assign n_s3_opr_b = ({`FRV_XLEN{s2_opr_src[`FRV_DIS_OPRB_RS2]}}  & dis_rs2)     |
                        ({`FRV_XLEN{s2_opr_src[`FRV_DIS_OPRB_IMM]}}  & s2_imm);
    assign n_s3_opr_c = ({`FRV_XLEN{s2_opr_src[`FRV_DIS_OPRC_RS2]}}  & dis_rs2)     |
                        ({`FRV_XLEN{s2_opr_src[`FRV_DIS_OPRC_CSRA]}} & csr_addr)    |
                        ({`FRV_XLEN{s2_opr_src[`FRV_DIS_OPRC_PCIM]}} & pc_plus_imm);

    // Stores and conditional branches write nothing, keep them off the forward path
    assign no_rd   = (s2_fu[`FRV_P_FU_LSU] && s2_uop[`FRV_LSU_STORE]) ||
                     (s2_fu[`FRV_P_FU_CFU] && s2_uop[4:3] == 2'b00);
    assign n_s3_rd = no_rd ? 5'd0 : s2_rd;

    // --------------------------------------------------
    // Pipeline register into s3
    // --------------------------------------------------
    assign pipe_if.valid = s2_p_valid;
    assign pipe_if.flush = flush || (dis_bubble && !pipe_if.busy); // Bubble in
    assign pipe_if.data  = {n_s3_rd, s2_pc, s2_uop, s2_fu, s2_size, s2_instr,
                            n_s3_opr_a, n_s3_opr_b, n_s3_opr_c, s2_trap};

    assign {s3_rd, s3_pc, s3_uop, s3_fu, s3_size, s3_instr,
            s3_opr_a, s3_opr_b, s3_opr_c, s3_trap} = pipe_reg_out;

    frv_gprs i_gprs (
        .g_clk   (g_clk),
        .arst_n  (arst_n),
        .rd_port (gpr_if.regfile),
        .rd_wen  (gpr_wen),
        .rd_addr (gpr_rd),
        .rd_data (gpr_wdata)
    );

    frv_pipeline_register #(
        .RLEN (`FRV_PIPE_REG_W)
    ) i_dispatch_pipe_reg (
        .g_clk   (g_clk),
        .arst_n  (arst_n),
        .in_port (pipe_if.sink),
        .o_data  (pipe_reg_out),
        .o_valid (s3_p_valid),
        .i_busy  (s3_p_busy)
    );

    // Decode must never ask for two operand A sources
    a_opra_onehot: assert property (
        @(posedge g_clk) disable iff (!arst_n)
        s2_p_valid |-> $onehot0(s2_opr_src[`FRV_DIS_OPRA_CSRI:`FRV_DIS_OPRA_RS1])
    ) else $error("Error: s2_opr_src operand A select 0x%h", s2_opr_src);

endmodule

`default_nettype wire

/* verilog/frv_pipeline_register.sv */
// --------------------------------------------------
// Single entry valid/busy pipeline register
// Loads when empty or when stage N+1 is not busy
// busy to stage N = o_valid && i_busy
// Flush clears valid only, data is left as is
// RLEN must match the connected interface width
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_pipeline_register #(
    parameter int RLEN = 32               // Record width
) (
    input  logic            g_clk,        // Core clock
    input  logic            arst_n,       // Async reset, active low
    frv_stage_in_if.sink    in_port,      // From stage N
    output logic [RLEN-1:0] o_data,       // To stage N+1
    output logic            o_valid,      // Record held for stage N+1
    input  logic            i_busy        // Stage N+1 stalled
);

    logic load_en; // Register can take a new record

    // Holding data that cannot leave
    assign in_port.busy = o_valid && i_busy;
    assign load_en      = !in_port.busy;

    // --------------------------------------------------
    // Valid and payload
    // --------------------------------------------------
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else if (in_port.flush) begin
            o_valid <= 1'b0;                 // Flush beats a load
        end else if (load_en) begin
            o_valid <= in_port.valid;        // Empty when nothing offered
            if (in_port.valid) begin
                o_data <= in_port.data;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/frv_gprs.sv */
// --------------------------------------------------
// 32 x XLEN general purpose register file
// Two combinational reads, one write per cycle
// No write-through: a write is seen next cycle
// x0 reads as zero, writes to it are dropped
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_gprs import frv_isa_pkg::*; (
    input  logic                 g_clk,   // Core clock
    input  logic                 arst_n,  // Async reset, active low
    frv_gpr_rd_if.regfile        rd_port, // Read ports to dispatch
    input  logic                 rd_wen,  // Write enable
    input  reg_addr_t            rd_addr, // Write index
    input  xword_t               rd_data  // Write value
);

    xword_t regs [1:31]; // x1..x31, x0 not stored

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                    // All registers start at 0
            end
        end else if (rd_wen && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;             // x0 writes ignored
        end
    end

    // --------------------------------------------------
    // Read ports
    // --------------------------------------------------
    assign rd_port.rs1_data = (rd_port.rs1_addr == 5'd0) ? '0 :
                              regs[rd_port.rs1_addr];     // x0 hardwired
    assign rd_port.rs2_data = (rd_port.rs2_addr == 5'd0) ? '0 :
                              regs[rd_port.rs2_addr];

    // Writeback must never present an X index with enable set
    a_wr_addr_known: assert property (
        @(posedge g_clk) disable iff (!arst_n)
        rd_wen |-> !$isunknown(rd_addr)
    ) else $error("Error: gpr write address unknown with rd_wen high");

endmodule

`default_nettype wire

/* verilog/frv_stage_ifs.sv */
// --------------------------------------------------
// Interfaces inside the dispatch stage
// GPR reads are combinational, same cycle
// Stage input transfers on valid && !busy
// Flush wins over a load at the same edge
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// Register file read port pair
// --------------------------------------------------
interface frv_gpr_rd_if import frv_isa_pkg::*; ();

    reg_addr_t rs1_addr; // Source 1 index
    reg_addr_t rs2_addr; // Source 2 index
    xword_t    rs1_data; // Source 1 value
    xword_t    rs2_data; // Source 2 value

    modport reader (
        output rs1_addr, rs2_addr,
        input  rs1_data, rs2_data
    );

    modport regfile (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );

endinterface

// --------------------------------------------------
// Input side of a pipeline register
// --------------------------------------------------
interface frv_stage_in_if #(
    parameter int RLEN = 32
) ();

    logic [RLEN-1:0] data;  // Record from stage N
    logic            valid; // Record present
    logic            busy;  // Register cannot take it
    logic            flush; // Empty on next edge

    modport source (output data, valid, flush, input busy);
    modport sink   (input data, valid, flush, output busy);

endinterface

`default_nettype wire

/* verilog/frv_dispatch_pkg.sv */
// --------------------------------------------------
// Backend pipeline field types
// Encodings are owned by decode; dispatch only
// routes them and tests the bits named in the
// constants header
// --------------------------------------------------

`default_nettype none

package frv_dispatch_pkg;

    // Micro-op code within its functional unit
    typedef logic [4:0] uop_t;

    // Functional unit select, one-hot
    typedef logic [4:0] fu_t;

    // Operand source mask
    // Bits 2:0 pick A, 4:3 pick B, 7:5 pick C
    typedef logic [7:0] opr_src_t;

    // Instruction size code
    // 01 = 16-bit, 10 = 32-bit
    typedef logic [1:0] instr_size_t;

endpackage

`default_nettype wire

/* verilog/frv_isa_pkg.sv */
// --------------------------------------------------
// Architectural types of the RV32 integer ISA
// Data word width follows FRV_XLEN
// --------------------------------------------------

`default_nettype none

`include "frv_consts.svh"

package frv_isa_pkg;

    // Register index, x0..x31
    typedef logic [4:0] reg_addr_t;

    // Register and operand data word
    typedef logic [`FRV_XLEN-1:0] xword_t;

    // Raw instruction encoding, always 32 bits here
    typedef logic [31:0] instr_t;

endpackage

`default_nettype wire

/* verilog/frv_consts.svh */
// --------------------------------------------------
// Backend constants shared by packages and RTL
// Bit positions must agree with the decode stage
// encodings of the functional unit and operand masks
// FRV_PIPE_REG_W must equal the packed s3 record
// --------------------------------------------------

`ifndef FRV_CONSTS_SVH
`define FRV_CONSTS_SVH

// --------------------------------------------------
// Data path widths
// --------------------------------------------------
`define FRV_XLEN             32  // Data word width
`define FRV_PIPE_REG_W       178 // rd+pc+uop+fu+size+instr+3 ops+trap

// --------------------------------------------------
// Functional unit one-hot positions
// --------------------------------------------------
`define FRV_P_FU_LSU         2   // Load/store unit
`define FRV_P_FU_CFU         3   // Control flow unit

// Micro-op bit marking an LSU store
`define FRV_LSU_STORE        4

// --------------------------------------------------
// Operand source mask bits
// --------------------------------------------------
`define FRV_DIS_OPRA_RS1     0   // A from rs1
`define FRV_DIS_OPRA_PCIM    1   // A from pc + imm
`define FRV_DIS_OPRA_CSRI    2   // A from CSR immediate
`define FRV_DIS_OPRB_RS2     3   // B from rs2
`define FRV_DIS_OPRB_IMM     4   // B from immediate
`define FRV_DIS_OPRC_RS2     5   // C from rs2
`define FRV_DIS_OPRC_CSRA    6   // C from CSR address
`define FRV_DIS_OPRC_PCIM    7   // C from pc + imm

`endif
